//--- verilog/sysid_pkg.sv
//////////////////////////////////////////////////
// System identification shared definitions
//////////////////////////////////////////////////

package sysid_pkg;

  // Bus and identifier widths
  localparam int ADDR_W = 16;
  localparam int DATA_W = 32;
  localparam int DNA_W  = 57;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] data_t;
  typedef logic [DNA_W-1:0]  dna_t;
  typedef logic [1:0]        resp_t;
  typedef logic [3:0]        strb_t;
  typedef logic [7:0]        led_t;
  typedef logic [8:0]        dna_cnt_t;

  // AXI response codes
  localparam resp_t RESP_OKAY   = 2'b00;
  localparam resp_t RESP_SLVERR = 2'b10;
  localparam resp_t RESP_DECERR = 2'b11;

  // Identity constants, board type in low nibble
  localparam dna_t  DNA_SIM_VALUE = 57'h1F1E_2D3C_4B5A_697;
  localparam data_t BOARD_ID      = 32'h0001_0002;
  localparam logic [159:0] GIT_HASH =
    160'h3f2a_9c41_07de_b815_6a20_e4c7_91bd_5f03_88a6_2c19;

  // Readout sequence points
  localparam dna_cnt_t DNA_READ_END    = 9'd10;
  localparam dna_cnt_t DNA_SHIFT_START = 9'd18;
  localparam dna_cnt_t DNA_DONE_COUNT  = 9'd465;
  localparam int       DNA_CLK_BIT     = 2;

  // Peer select on the upper nibble, anything above HK unmapped
  localparam addr_t PEER_MASK  = 16'hF000;
  localparam addr_t OFF_MASK   = 16'h0FFF;
  localparam addr_t SYSID_BASE = 16'h0000;
  localparam addr_t HK_BASE    = 16'h1000;

  // sysid register offsets
  localparam addr_t SYSID_ID     = 16'h0000;
  localparam addr_t SYSID_DNA_LO = 16'h0004;
  localparam addr_t SYSID_DNA_HI = 16'h0008;
  localparam addr_t SYSID_STATUS = 16'h000C;
  localparam addr_t SYSID_HASH0  = 16'h0010;
  localparam addr_t SYSID_HASH1  = 16'h0014;
  localparam addr_t SYSID_HASH2  = 16'h0018;
  localparam addr_t SYSID_HASH3  = 16'h001C;
  localparam addr_t SYSID_HASH4  = 16'h0020;

  // Housekeeping register offsets
  localparam addr_t HK_SCRATCH = 16'h0000;
  localparam addr_t HK_LED     = 16'h0004;

  // Arbiter FSM
  typedef enum logic [1:0] {
    IDLE,
    BUS,
    RESP_W,
    RESP_R
  } arb_state_t;

endpackage

//--- verilog/dna_port_model.sv
//////////////////////////////////////////////////
// Device identifier port model
//////////////////////////////////////////////////

module dna_port_model (
  input  logic rst,
  input  logic dna_clk,
  input  logic dna_read,
  input  logic dna_shift,
  output logic dna_dout
);

  // Identifier shift register
  sysid_pkg::dna_t dna_sr;

  //////////////////////////////////////////////////
  // Load and shift
  //////////////////////////////////////////////////

  // Runs on the slow port clock from sysid_regs
  always_ff @(posedge dna_clk) begin
    if (rst) begin
      dna_sr <= '0;
    end else if (dna_read) begin
      // Load has priority over shift
      dna_sr <= sysid_pkg::DNA_SIM_VALUE;
    end else if (dna_shift) begin
      // Toward MSB, zero fill from the bottom
      dna_sr <= {dna_sr[sysid_pkg::DNA_W-2:0], 1'b0};
    end
  end

  //////////////////////////////////////////////////
  // Output
  //////////////////////////////////////////////////

  // Top bit always visible
  assign dna_dout = dna_sr[sysid_pkg::DNA_W-1];

endmodule

//--- verilog/sysid_regs.sv
//////////////////////////////////////////////////
// System identification registers
//////////////////////////////////////////////////

module sysid_regs (
  input  logic             rst,
  input  logic             bus,
  input  sysid_pkg::addr_t reg_addr,
  input  sysid_pkg::data_t reg_wdata,
  input  logic             wen,
  input  logic             ren,
  output sysid_pkg::data_t rdata,
  output logic             ack,
  output logic             err,
  output logic             dna_clk,
  output logic             dna_read,
  output logic             dna_shift,
  input  logic             dna_dout
);

  // Readout sequence state
  sysid_pkg::dna_cnt_t dna_cnt;
  sysid_pkg::dna_t     dna_value;
  logic                dna_done;

  // Register offset within the peer
  sysid_pkg::addr_t off;

  //////////////////////////////////////////////////
  // Identifier readout
  //////////////////////////////////////////////////

  always_ff @(posedge bus) begin
    if (rst) begin
      dna_cnt   <= '0;
      dna_clk   <= 1'b0;
      dna_read  <= 1'b0;
      dna_shift <= 1'b0;
      dna_done  <= 1'b0;
    end else begin
      // Counter stops once readout is over
      if (!dna_done) begin
        dna_cnt <= dna_cnt + 9'd1;
      end
      // Port clock is count bit 2, period of 8 bus cycles
      dna_clk   <= dna_cnt[sysid_pkg::DNA_CLK_BIT];
      // Load window first, then shift
      dna_read  <= (dna_cnt < sysid_pkg::DNA_READ_END);
      dna_shift <= (dna_cnt > sysid_pkg::DNA_SHIFT_START);
      if (dna_cnt > sysid_pkg::DNA_DONE_COUNT) begin
        dna_done <= 1'b1;
      end
    end
  end

  // Sample once per port clock period, before its rising edge
  // First two samples fall out the top of the register
  always_ff @(posedge bus) begin
    if ((dna_cnt[sysid_pkg::DNA_CLK_BIT:0] == '0) && !dna_done) begin
      dna_value <= {dna_value[sysid_pkg::DNA_W-2:0], dna_dout};
    end
  end

  //////////////////////////////////////////////////
  // Register bus
  //////////////////////////////////////////////////

  assign off = reg_addr & sysid_pkg::OFF_MASK;

  // Every access answered next cycle, writes rejected
  always_ff @(posedge bus) begin
    if (rst) begin
      ack <= 1'b0;
      err <= 1'b0;
    end else begin
      ack <= wen | ren;
      err <= wen;
    end
  end

  // Read mux
  always_ff @(posedge bus) begin
    if (ren) begin
      case (off)
        sysid_pkg::SYSID_ID:     rdata <= sysid_pkg::BOARD_ID;
        sysid_pkg::SYSID_DNA_LO: rdata <= dna_value[31:0];
        // High word zero extended
        sysid_pkg::SYSID_DNA_HI: rdata <= {7'd0, dna_value[sysid_pkg::DNA_W-1:32]};
        sysid_pkg::SYSID_STATUS: rdata <= {31'd0, dna_done};
        sysid_pkg::SYSID_HASH0:  rdata <= sysid_pkg::GIT_HASH[0*sysid_pkg::DATA_W +: 32];
        sysid_pkg::SYSID_HASH1:  rdata <= sysid_pkg::GIT_HASH[1*sysid_pkg::DATA_W +: 32];
        sysid_pkg::SYSID_HASH2:  rdata <= sysid_pkg::GIT_HASH[2*sysid_pkg::DATA_W +: 32];
        sysid_pkg::SYSID_HASH3:  rdata <= sysid_pkg::GIT_HASH[3*sysid_pkg::DATA_W +: 32];
        sysid_pkg::SYSID_HASH4:  rdata <= sysid_pkg::GIT_HASH[4*sysid_pkg::DATA_W +: 32];
        default:                 rdata <= '0;
      endcase
    end
  end

endmodule

//--- verilog/housekeeping_regs.sv
//////////////////////////////////////////////////
// Housekeeping registers
//////////////////////////////////////////////////

module housekeeping_regs (
  input  logic             rst,
  input  logic             bus,
  input  sysid_pkg::addr_t reg_addr,
  input  sysid_pkg::data_t reg_wdata,
  input  logic             wen,
  input  logic             ren,
  output sysid_pkg::data_t rdata,
  output logic             ack,
  output logic             err,
  output sysid_pkg::led_t  led
);

  sysid_pkg::addr_t off;
  sysid_pkg::data_t scratch;

  assign off = reg_addr & sysid_pkg::OFF_MASK;

  // No access is ever rejected here
  assign err = 1'b0;

  //////////////////////////////////////////////////
  // Writes and acknowledge
  //////////////////////////////////////////////////

  always_ff @(posedge bus) begin
    if (rst) begin
      ack <= 1'b0;
      led <= '0;
    end else begin
      ack <= wen | ren;
      // Only low byte kept for LEDs
      if (wen && (off == sysid_pkg::HK_LED)) begin
        led <= reg_wdata[7:0];
      end
    end
  end

  // Scratch word, full width
  always_ff @(posedge bus) begin
    if (wen && (off == sysid_pkg::HK_SCRATCH)) begin
      scratch <= reg_wdata;
    end
  end

  // Read mux, unknown offsets give zero
  always_ff @(posedge bus) begin
    if (ren) begin
      case (off)
        sysid_pkg::HK_SCRATCH: rdata <= scratch;
        sysid_pkg::HK_LED:     rdata <= {24'd0, led};
        default:               rdata <= '0;
      endcase
    end
  end

endmodule

//--- verilog/axil_bus_arbiter.sv
//////////////////////////////////////////////////
// AXI4-Lite to register bus arbiter
//////////////////////////////////////////////////

module axil_bus_arbiter (
  input  logic              rst,
  input  logic              bus,
  input  sysid_pkg::addr_t  awaddr,
  input  logic              awvalid,
  output logic              awready,
  input  sysid_pkg::data_t  wdata,
  input  sysid_pkg::strb_t  wstrb,
  input  logic              wvalid,
  output logic              wready,
  output sysid_pkg::resp_t  bresp,
  output logic              bvalid,
  input  logic              bready,
  input  sysid_pkg::addr_t  araddr,
  input  logic              arvalid,
  output logic              arready,
  output sysid_pkg::data_t  rdata,
  output sysid_pkg::resp_t  rresp,
  output logic              rvalid,
  input  logic              rready,
  output sysid_pkg::addr_t  reg_addr,
  output sysid_pkg::data_t  reg_wdata,
  output logic              sysid_wen,
  output logic              sysid_ren,
  output logic              hk_wen,
  output logic              hk_ren,
  input  sysid_pkg::data_t  sysid_rdata,
  input  logic              sysid_ack,
  input  logic              sysid_err,
  input  sysid_pkg::data_t  hk_rdata,
  input  logic              hk_ack,
  input  logic              hk_err
);

  sysid_pkg::arb_state_t state;
  // Set when the last (or current) transaction is a write
  logic             last_w;
  logic             peer_hk;
  logic             grant_w;
  logic             grant_r;
  logic             acc_hk;
  logic             acc_map;
  sysid_pkg::addr_t acc_addr;
  logic             peer_ack;
  logic             peer_err;
  sysid_pkg::data_t peer_rdata;
  sysid_pkg::resp_t peer_resp;

  //////////////////////////////////////////////////
  // Channel grant and address decode
  //////////////////////////////////////////////////

  // Alternate when both channels pend, write needs AW and W together
  // Byte strobes ignored, every write is a full word
  assign grant_w = (state == sysid_pkg::IDLE) && awvalid && wvalid &&
                   (!arvalid || !last_w);
  assign grant_r = (state == sysid_pkg::IDLE) && arvalid && !grant_w;

  assign awready = grant_w;
  assign wready  = grant_w;
  assign arready = grant_r;

  assign acc_addr = grant_w ? awaddr : araddr;
  assign acc_hk   = (acc_addr & sysid_pkg::PEER_MASK) == sysid_pkg::HK_BASE;
  assign acc_map  = acc_hk || ((acc_addr & sysid_pkg::PEER_MASK) == sysid_pkg::SYSID_BASE);

  // Answer from the peer in service
  assign peer_ack   = peer_hk ? hk_ack : sysid_ack;
  assign peer_err   = peer_hk ? hk_err : sysid_err;
  assign peer_rdata = peer_hk ? hk_rdata : sysid_rdata;
  assign peer_resp  = peer_err ? sysid_pkg::RESP_SLVERR : sysid_pkg::RESP_OKAY;

  //////////////////////////////////////////////////
  // FSM
  //////////////////////////////////////////////////

  always_ff @(posedge bus) begin
    if (rst) begin
      state     <= sysid_pkg::IDLE;
      last_w    <= 1'b0;
      bvalid    <= 1'b0;
      rvalid    <= 1'b0;
      sysid_wen <= 1'b0;
      sysid_ren <= 1'b0;
      hk_wen    <= 1'b0;
      hk_ren    <= 1'b0;
    end else begin
      // Strobes last one cycle
      sysid_wen <= 1'b0;
      sysid_ren <= 1'b0;
      hk_wen    <= 1'b0;
      hk_ren    <= 1'b0;
      case (state)
        sysid_pkg::IDLE: begin
          if (grant_w || grant_r) begin
            last_w <= grant_w;
            if (acc_map) begin
              state     <= sysid_pkg::BUS;
              sysid_wen <= grant_w && !acc_hk;
              sysid_ren <= grant_r && !acc_hk;
              hk_wen    <= grant_w && acc_hk;
              hk_ren    <= grant_r && acc_hk;
            end else if (grant_w) begin
              // Unmapped, skip the bus
              state  <= sysid_pkg::RESP_W;
              bvalid <= 1'b1;
            end else begin
              state  <= sysid_pkg::RESP_R;
              rvalid <= 1'b1;
            end
          end
        end
        sysid_pkg::BUS: begin
          if (peer_ack) begin
            state  <= last_w ? sysid_pkg::RESP_W : sysid_pkg::RESP_R;
            bvalid <= last_w;
            rvalid <= !last_w;
          end
        end
        // Hold response until taken
        sysid_pkg::RESP_W: begin
          if (bready) begin
            bvalid <= 1'b0;
            state  <= sysid_pkg::IDLE;
          end
        end
        sysid_pkg::RESP_R: begin
          if (rready) begin
            rvalid <= 1'b0;
            state  <= sysid_pkg::IDLE;
          end
        end
        default: state <= sysid_pkg::IDLE;
      endcase
    end
  end

  //////////////////////////////////////////////////
  // Payload
  //////////////////////////////////////////////////

  always_ff @(posedge bus) begin
    if (grant_w || grant_r) begin
      reg_addr  <= acc_addr;
      reg_wdata <= wdata;
      peer_hk   <= acc_hk;
      if (!acc_map) begin
        bresp <= sysid_pkg::RESP_DECERR;
        rresp <= sysid_pkg::RESP_DECERR;
        rdata <= '0;
      end
    end
    if ((state == sysid_pkg::BUS) && peer_ack) begin
      if (last_w) begin
        bresp <= peer_resp;
      end else begin
        rresp <= peer_resp;
        rdata <= peer_rdata;
      end
    end
  end

endmodule

//--- verilog/sysid_top.sv
//////////////////////////////////////////////////
// System identification top
//////////////////////////////////////////////////

module sysid_top (
  input  logic             rst,
  input  logic             bus,
  input  sysid_pkg::addr_t awaddr,
  input  logic             awvalid,
  output logic             awready,
  input  sysid_pkg::data_t wdata,
  input  sysid_pkg::strb_t wstrb,
  input  logic             wvalid,
  output logic             wready,
  output sysid_pkg::resp_t bresp,
  output logic             bvalid,
  input  logic             bready,
  input  sysid_pkg::addr_t araddr,
  input  logic             arvalid,
  output logic             arready,
  output sysid_pkg::data_t rdata,
  output sysid_pkg::resp_t rresp,
  output logic             rvalid,
  input  logic             rready,
  output sysid_pkg::led_t  led
);

  // Shared register bus
  sysid_pkg::addr_t reg_addr;
  sysid_pkg::data_t reg_wdata;
  logic             sysid_wen, sysid_ren, hk_wen, hk_ren;
  sysid_pkg::data_t sysid_rdata, hk_rdata;
  logic             sysid_ack, sysid_err, hk_ack, hk_err;

  // Identifier port
  logic dna_clk, dna_read, dna_shift, dna_dout;

  axil_bus_arbiter u_arb (
    .rst, .bus,
    .awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
    .bresp, .bvalid, .bready, .araddr, .arvalid, .arready,
    .rdata, .rresp, .rvalid, .rready,
    .reg_addr, .reg_wdata, .sysid_wen, .sysid_ren, .hk_wen, .hk_ren,
    .sysid_rdata, .sysid_ack, .sysid_err, .hk_rdata, .hk_ack, .hk_err
  );

  sysid_regs u_sysid (
    .rst, .bus, .reg_addr, .reg_wdata,
    .wen (sysid_wen), .ren (sysid_ren),
    .rdata (sysid_rdata), .ack (sysid_ack), .err (sysid_err),
    .dna_clk, .dna_read, .dna_shift, .dna_dout
  );

  housekeeping_regs u_hk (
    .rst, .bus, .reg_addr, .reg_wdata,
    .wen (hk_wen), .ren (hk_ren),
    .rdata (hk_rdata), .ack (hk_ack), .err (hk_err), .led
  );

  dna_port_model u_dna (
    .rst, .dna_clk, .dna_read, .dna_shift, .dna_dout
  );

endmodule

//--- tb/tb_clock.sv
//////////////////////////////////////////////////
// Testbench clock
//////////////////////////////////////////////////

module tb_clock (
  output logic bus
);

  // Half period 10, full period 20
  initial begin
    bus = 1'b0;
    forever #10 bus = ~bus;
  end

endmodule

//--- tb/sysid_assert.sv
//////////////////////////////////////////////////
// AXI4-Lite and register bus assertions
//////////////////////////////////////////////////

module sysid_assert (
  input logic bus,
  input logic rst,
  input logic bvalid,
  input logic bready,
  input logic rvalid,
  input logic rready,
  input logic sysid_wen,
  input logic sysid_ren,
  input logic hk_wen,
  input logic hk_ren,
  input logic sysid_ack,
  input logic hk_ack
);

  // Responses held until taken
  a_bvalid_hold: assert property (@(posedge bus) disable iff (rst)
    bvalid && !bready |=> bvalid) else $error("bvalid dropped before bready");
  a_rvalid_hold: assert property (@(posedge bus) disable iff (rst)
    rvalid && !rready |=> rvalid) else $error("rvalid dropped before rready");

  // One strobe at a time on the shared bus
  a_one_strobe: assert property (@(posedge bus) disable iff (rst)
    $onehot0({sysid_wen, sysid_ren, hk_wen, hk_ren})) else $error("several strobes high");

  // Ack exactly one cycle after strobe
  a_sysid_ack: assert property (@(posedge bus) disable iff (rst)
    sysid_ack == $past(sysid_wen || sysid_ren)) else $error("sysid ack out of step");
  a_hk_ack: assert property (@(posedge bus) disable iff (rst)
    hk_ack == $past(hk_wen || hk_ren)) else $error("housekeeping ack out of step");

endmodule

bind sysid_top sysid_assert u_assert (
  .bus, .rst, .bvalid, .bready, .rvalid, .rready,
  .sysid_wen, .sysid_ren, .hk_wen, .hk_ren, .sysid_ack, .hk_ack
);

//--- tb/sysid_tb.sv
//////////////////////////////////////////////////
// System identification testbench
//////////////////////////////////////////////////

module sysid_tb;

  logic bus;
  logic rst;

  // AXI4-Lite side of the DUT
  sysid_pkg::addr_t awaddr, araddr;
  sysid_pkg::data_t wdata, rdata;
  sysid_pkg::strb_t wstrb;
  sysid_pkg::resp_t bresp, rresp;
  sysid_pkg::led_t  led;
  logic awvalid, awready, wvalid, wready, bvalid, bready;
  logic arvalid, arready, rvalid, rready;

  // Stimulus table, one entry per test line
  logic [8*24-1:0]  name_q[$];
  logic [8*8-1:0]   op_q[$];
  sysid_pkg::addr_t addr_q[$];
  sysid_pkg::data_t wdata_q[$];
  sysid_pkg::data_t exp_q[$];
  sysid_pkg::resp_t resp_q[$];

  int  n_tests;
  int  test_errs;
  int  load_errs;
  int  pass_count;
  int  fail_count;
  bit  loaded;
  time w_time;
  time r_time;

  tb_clock u_clk (.bus);

  sysid_top UUT (
    .rst, .bus, .awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
    .bresp, .bvalid, .bready, .araddr, .arvalid, .arready,
    .rdata, .rresp, .rvalid, .rready, .led
  );

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////

  task automatic compare_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
    if (got !== exp) begin
      $display("** Error at time %0t: %s is %h, expected %h", $time, what, got, exp);
      test_errs++;
    end
  endtask

  // Parse lines of six fields, anything else is a comment
  task automatic load_stimulus();
    integer          fd;
    integer          code;
    logic [8*160-1:0] line;
    logic [8*24-1:0] name;
    logic [8*8-1:0]  op;
    logic [31:0]     a, d, e, r;
    fd = $fopen("tb/sysid_stimulus.txt", "r");
    if (fd == 0) begin
      $display("Could not open the stimulus file");
      load_errs++;
    end else begin
      while ($fgets(line, fd) != 0) begin
        code = $sscanf(line, "%s %s %h %h %h %h", name, op, a, d, e, r);
        if (code == 6) begin
          name_q.push_back(name);
          op_q.push_back(op);
          addr_q.push_back(a[15:0]);
          wdata_q.push_back(d);
          exp_q.push_back(e);
          resp_q.push_back(r[1:0]);
        end
      end
      $fclose(fd);
    end
    n_tests = name_q.size();
  endtask

  // Full word write, waits for handshake then the B response
  task automatic write_word(input sysid_pkg::addr_t a, input sysid_pkg::data_t d,
                            output sysid_pkg::resp_t r);
    @(posedge bus);
    #2;
    awaddr  = a;
    wdata   = d;
    wstrb   = 4'hF;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    @(negedge bus);
    while (!awready) @(negedge bus);
    w_time = $time;
    // Both write channel readies pulse together
    compare_value("wready", {31'd0, wready}, 32'd1);
    @(posedge bus);
    #2;
    awvalid = 1'b0;
    wvalid  = 1'b0;
    @(negedge bus);
    while (!bvalid) @(negedge bus);
    r = bresp;
    // bready high, response taken here
    @(posedge bus);
  endtask

  task automatic read_word(input sysid_pkg::addr_t a, output sysid_pkg::data_t d,
                           output sysid_pkg::resp_t r);
    @(posedge bus);
    #2;
    araddr  = a;
    arvalid = 1'b1;
    @(negedge bus);
    while (!arready) @(negedge bus);
    r_time = $time;
    @(posedge bus);
    #2;
    arvalid = 1'b0;
    @(negedge bus);
    while (!rvalid) @(negedge bus);
    d = rdata;
    r = rresp;
    @(posedge bus);
  endtask

  //////////////////////////////////////////////////
  // One stimulus line
  //////////////////////////////////////////////////

  task automatic run_test(input int i);
    sysid_pkg::data_t got_d;
    sysid_pkg::data_t exp_d;
    sysid_pkg::resp_t got_b;
    sysid_pkg::resp_t got_r;
    int               polls;
    test_errs = 0;
    if (op_q[i] == "write") begin
      write_word(addr_q[i], wdata_q[i], got_b);
      compare_value("bresp", {30'd0, got_b}, {30'd0, resp_q[i]});
      // LED port follows the low byte
      if (addr_q[i] == (sysid_pkg::HK_BASE | sysid_pkg::HK_LED)) begin
        compare_value("led", {24'd0, led}, {24'd0, wdata_q[i][7:0]});
      end
    end else if (op_q[i] == "read") begin
      read_word(addr_q[i], got_d, got_r);
      compare_value("rresp", {30'd0, got_r}, {30'd0, resp_q[i]});
      if (resp_q[i] == sysid_pkg::RESP_OKAY) begin
        compare_value("rdata", got_d, exp_q[i]);
      end
    end else if (op_q[i] == "poll") begin
      // Readout takes about 470 cycles, 5 cycles per read
      polls = 0;
      read_word(addr_q[i], got_d, got_r);
      while ((got_d !== exp_q[i]) && (polls < 200)) begin
        polls++;
        read_word(addr_q[i], got_d, got_r);
      end
      if (got_d !== exp_q[i]) begin
        $display("Polling at %h never reached the expected value", addr_q[i]);
        test_errs++;
      end
      compare_value("rresp", {30'd0, got_r}, {30'd0, resp_q[i]});
    end else if (op_q[i] == "both") begin
      fork
        write_word(addr_q[i], wdata_q[i], got_b);
        read_word(addr_q[i], got_d, got_r);
      join
      compare_value("bresp", {30'd0, got_b}, {30'd0, resp_q[i]});
      compare_value("rresp", {30'd0, got_r}, {30'd0, resp_q[i]});
      // Read served first sees the old word, else the new one
      exp_d = (r_time < w_time) ? exp_q[i] : wdata_q[i];
      if (resp_q[i] == sysid_pkg::RESP_OKAY) begin
        compare_value("rdata", got_d, exp_d);
      end
    end else begin
      $display("Unknown operation on stimulus entry %0d", i);
      test_errs++;
    end
    if (test_errs == 0) begin
      pass_count++;
      $display("PASS %0s", name_q[i]);
    end else begin
      fail_count++;
      $display("FAIL %0s", name_q[i]);
    end
  endtask

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////

  initial begin
    rst     = 1'b1;
    awaddr  = '0;
    awvalid = 1'b0;
    wdata   = '0;
    wstrb   = '0;
    wvalid  = 1'b0;
    bready  = 1'b1;
    araddr  = '0;
    arvalid = 1'b0;
    rready  = 1'b1;
    load_stimulus();
    loaded = 1'b1;
    repeat (4) @(posedge bus);
    #2;
    rst = 1'b0;
    for (int i = 0; i < n_tests; i++) begin
      run_test(i);
    end
    $display("Summary: %0d passed, %0d failed", pass_count, fail_count);
    if ((fail_count == 0) && (load_errs == 0) && (n_tests > 0)) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

  // Watchdog, 100 cycles per line plus the readout
  initial begin
    wait (loaded);
    repeat (n_tests * 100 + 1000) @(posedge bus);
    $display("The run timed out before all tests finished");
    $display("test failed");
    $finish;
  end

endmodule

//--- tb/sysid_stimulus.txt
# Columns: test name, operation, address, write data, expected read data, response
# Responses: 0 OKAY, 2 SLVERR, 3 DECERR
id_read         read   0000 00000000 00010002 0
hash0_read      read   0010 00000000 88a62c19 0
hash1_read      read   0014 00000000 91bd5f03 0
hash2_read      read   0018 00000000 6a20e4c7 0
hash3_read      read   001c 00000000 07deb815 0
hash4_read      read   0020 00000000 3f2a9c41 0
status_poll     poll   000c 00000000 00000001 0
dna_lo_read     read   0004 00000000 c4b5a697 0
dna_hi_read     read   0008 00000000 01f1e2d3 0
id_write        write  0000 deadbeef 00000000 2
id_recheck      read   0000 00000000 00010002 0
dna_lo_write    write  0004 12345678 00000000 2
dna_lo_recheck  read   0004 00000000 c4b5a697 0
sysid_unknown   read   0030 00000000 00000000 0
scratch_write   write  1000 a5c30f96 00000000 0
scratch_read    read   1000 00000000 a5c30f96 0
led_write       write  1004 123456c9 00000000 0
led_read        read   1004 00000000 000000c9 0
decerr_write    write  2000 11111111 00000000 3
decerr_read     read   2000 00000000 00000000 3
decerr_top      read   ffff 00000000 00000000 3
both_scratch    both   1000 0badf00d a5c30f96 0
both_decerr     both   3000 22222222 00000000 3
scratch_final   read   1000 00000000 0badf00d 0

//--- sysid_top.f
verilog/sysid_pkg.sv
verilog/dna_port_model.sv
verilog/sysid_regs.sv
verilog/housekeeping_regs.sv
verilog/axil_bus_arbiter.sv
verilog/sysid_top.sv
tb/tb_clock.sv
tb/sysid_assert.sv
tb/sysid_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the sysid testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sysid_top.f --top-module sysid_tb \
  --Mdir obj_dir -o sysid_sim

# An assertion stop exits nonzero, the output still decides the result
out=$(./obj_dir/sysid_sim) || true
echo "$out"

if echo "$out" | grep -qx "test passed"; then
  exit 0
else
  exit 1
fi
